// ==== hdl/csr_cmd_decoder.sv ====
`timescale 1ns/1ps

module csr_cmd_decoder #(
    parameter int N_HARTS = 4,
    parameter int HART_W  = 2
) (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic                           req_i,
    input  logic [2:0]                     funct3_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
    input  logic [4:0]                     rs1_i,
    input  logic [csr_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [4:0]                     rd_i,
    input  logic [HART_W-1:0]              hart_i,
    input  logic [csr_pkg::XLEN-1:0]       pc_i,
    input  logic                           ecall_i,
    output logic                           cmd_valid_o,
    output logic [N_HARTS-1:0]             cmd_sel_o,
    output logic [csr_pkg::OP_NUM-1:0]     cmd_op_o,
    output logic [csr_pkg::CSR_ADDR_W-1:0] cmd_addr_o,
    output logic [csr_pkg::XLEN-1:0]       cmd_operand_o,
    output logic                           cmd_wen_o,
    output logic                           cmd_ren_o,
    output logic [csr_pkg::XLEN-1:0]       cmd_pc_o,
    output logic [4:0]                     cmd_rd_o,
    output logic [HART_W-1:0]              cmd_hart_o,
    output logic                           cmd_ecall_o
);
    import csr_pkg::*;

    logic [OP_NUM-1:0]  op_d;
    logic [XLEN-1:0]    operand_d;
    logic               wen_d;
    logic               ren_d;
    logic [N_HARTS-1:0] sel_d;
    logic               rs1_nz;

    assign rs1_nz = |rs1_i; // also the uimm field for the immediate forms

    always_comb begin
        op_d      = '0;
        operand_d = rs1_data_i;
        wen_d     = 1'b0;
        ren_d     = 1'b0;
        if (ecall_i) begin
            op_d[OP_ECALL] = 1'b1;
            wen_d          = 1'b1; // mepc and mcause, no read
        end else begin
            case (funct3_i)
                F3_CSRRW, F3_CSRRWI: begin
                    op_d[OP_RW] = 1'b1;
                    wen_d       = 1'b1;
                    ren_d       = |rd_i; // rd x0 skips the read side effect
                end
                F3_CSRRS, F3_CSRRSI: begin
                    op_d[OP_RS] = 1'b1;
                    wen_d       = rs1_nz;
                    ren_d       = 1'b1;
                end
                F3_CSRRC, F3_CSRRCI: begin
                    op_d[OP_RC] = 1'b1;
                    wen_d       = rs1_nz;
                    ren_d       = 1'b1;
                end
                default: ; // reserved encodings do nothing
            endcase
            if (funct3_i[2]) begin
                operand_d = {{(XLEN-5){1'b0}}, rs1_i};
            end
        end
    end

    // one-hot hart select
    always_comb begin
        sel_d = '0;
        for (int h = 0; h < N_HARTS; h++) begin
            if (req_i && (hart_i == HART_W'(h))) begin
                sel_d[h] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cmd_valid_o <= 1'b0;
            cmd_sel_o   <= '0;
            cmd_op_o    <= '0;
            cmd_wen_o   <= 1'b0;
            cmd_ren_o   <= 1'b0;
            cmd_ecall_o <= 1'b0;
        end else begin
            cmd_valid_o <= req_i;
            cmd_sel_o   <= sel_d;
            cmd_op_o    <= req_i ? op_d : '0;
            cmd_wen_o   <= req_i & wen_d;
            cmd_ren_o   <= req_i & ren_d;
            cmd_ecall_o <= req_i & ecall_i;
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (req_i) begin
            cmd_addr_o    <= csr_addr_i;
            cmd_operand_o <= operand_d;
            cmd_pc_o      <= pc_i;
            cmd_rd_o      <= rd_i;
            cmd_hart_o    <= hart_i;
        end
    end

endmodule

// ==== hdl/csr_file.sv ====
`timescale 1ns/1ps

module csr_file #(
    parameter int unsigned HART_ID = 0
) (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic                           sel_i,
    input  logic [csr_pkg::OP_NUM-1:0]     op_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] addr_i,
    input  logic [csr_pkg::XLEN-1:0]       operand_i,
    input  logic                           wen_i,
    input  logic                           ren_i,
    input  logic [csr_pkg::XLEN-1:0]       pc_i,
    output logic [csr_pkg::XLEN-1:0]       rdata_o,
    output logic [csr_pkg::XLEN-1:0]       mtvec_o
);
    import csr_pkg::*;

    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;

    logic [XLEN-1:0] old_val;
    logic [XLEN-1:0] wdata;
    logic            csr_wr;
    logic            ecall_wr;

    // read mux, also the old value for read-modify-write
    always_comb begin
        case (addr_i)
            CSR_MSTATUS:   old_val = mstatus;
            CSR_MTVEC:     old_val = mtvec;
            CSR_MEPC:      old_val = mepc;
            CSR_MCAUSE:    old_val = mcause;
            CSR_MVENDORID: old_val = VENDOR_ID;
            CSR_MARCHID:   old_val = ARCH_ID;
            CSR_MHARTID:   old_val = XLEN'(HART_ID);
            default:       old_val = '0; // unimplemented
        endcase
    end

    assign rdata_o = (sel_i && ren_i) ? old_val : '0;
    assign mtvec_o = mtvec;

    always_comb begin
        wdata = operand_i;
        if (op_i[OP_RS]) begin
            wdata = old_val | operand_i;
        end else if (op_i[OP_RC]) begin
            wdata = old_val & ~operand_i;
        end
    end

    assign csr_wr   = sel_i && wen_i && (op_i[OP_RW] || op_i[OP_RS] || op_i[OP_RC]);
    assign ecall_wr = sel_i && wen_i && op_i[OP_ECALL];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else begin
            // first port, csr instructions
            if (csr_wr) begin
                case (addr_i)
                    CSR_MSTATUS: mstatus <= wdata;
                    CSR_MTVEC:   mtvec   <= wdata;
                    CSR_MEPC:    mepc    <= wdata;
                    CSR_MCAUSE:  mcause  <= wdata;
                    default:     ; // read-only or unimplemented, dropped
                endcase
            end
            // second port, ecall writes mepc and mcause together
            if (ecall_wr) begin
                mepc   <= pc_i;
                mcause <= CAUSE_ECALL_M;
            end
        end
    end

endmodule

// ==== hdl/csr_pkg.sv ====
package csr_pkg;

    // data and address widths
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // writable machine-mode csrs
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;

    // read-only identity csrs
    localparam logic [CSR_ADDR_W-1:0] CSR_MVENDORID = 12'hf11;
    localparam logic [CSR_ADDR_W-1:0] CSR_MARCHID   = 12'hf12;
    localparam logic [CSR_ADDR_W-1:0] CSR_MHARTID   = 12'hf14;

    localparam logic [XLEN-1:0] VENDOR_ID = 32'h0000_0000; // non-commercial implementation
    localparam logic [XLEN-1:0] ARCH_ID   = 32'h0000_1a05;

    // environment call from m-mode
    localparam logic [XLEN-1:0] CAUSE_ECALL_M = 32'd11;

    // bit positions in the one-hot operation vector
    typedef enum logic [1:0] {
        OP_RW    = 2'd0,
        OP_RS    = 2'd1,
        OP_RC    = 2'd2,
        OP_ECALL = 2'd3
    } csr_op_e;

    localparam int OP_NUM = 4;

    // funct3 of the SYSTEM opcode
    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRS  = 3'b010;
    localparam logic [2:0] F3_CSRRC  = 3'b011;
    localparam logic [2:0] F3_CSRRWI = 3'b101;
    localparam logic [2:0] F3_CSRRSI = 3'b110;
    localparam logic [2:0] F3_CSRRCI = 3'b111;

endpackage

// ==== hdl/csr_rsp_collector.sv ====
`timescale 1ns/1ps

module csr_rsp_collector #(
    parameter int N_HARTS = 4,
    parameter int HART_W  = 2
) (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     cmd_valid_i,
    input  logic                     cmd_ecall_i,
    input  logic [HART_W-1:0]        cmd_hart_i,
    input  logic [4:0]               cmd_rd_i,
    input  logic [csr_pkg::XLEN-1:0] hart_rdata_i [N_HARTS],
    input  logic [csr_pkg::XLEN-1:0] hart_mtvec_i [N_HARTS],
    output logic                     rsp_valid_o,
    output logic                     trap_valid_o,
    output logic [HART_W-1:0]        rsp_hart_o,
    output logic [4:0]               rsp_rd_o,
    output logic [csr_pkg::XLEN-1:0] rsp_rdata_o,
    output logic [csr_pkg::XLEN-1:0] trap_pc_o
);
    import csr_pkg::*;

    logic [XLEN-1:0] sel_rdata;
    logic [XLEN-1:0] sel_mtvec;

    // hart index beyond N_HARTS reads as zero
    always_comb begin
        sel_rdata = '0;
        sel_mtvec = '0;
        for (int h = 0; h < N_HARTS; h++) begin
            if (cmd_hart_i == HART_W'(h)) begin
                sel_rdata = hart_rdata_i[h];
                sel_mtvec = hart_mtvec_i[h]; // still the pre-ecall value
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_o  <= 1'b0;
            trap_valid_o <= 1'b0;
        end else begin
            rsp_valid_o  <= cmd_valid_i & ~cmd_ecall_i;
            trap_valid_o <= cmd_valid_i & cmd_ecall_i;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid_i) begin
            rsp_hart_o <= cmd_hart_i;
            if (cmd_ecall_i) begin
                trap_pc_o <= sel_mtvec;
            end else begin
                rsp_rd_o    <= cmd_rd_i;
                rsp_rdata_o <= sel_rdata;
            end
        end
    end

endmodule

// ==== hdl/csr_subsystem.sv ====
`timescale 1ns/1ps

module csr_subsystem #(
    parameter int N_HARTS = 4,
    parameter int HART_W  = 2
) (
    input  logic                           clk,
    input  logic                           arst_n_i,
    // request from execute
    input  logic                           req_i,
    input  logic [2:0]                     funct3_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
    input  logic [4:0]                     rs1_i,
    input  logic [csr_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [4:0]                     rd_i,
    input  logic [HART_W-1:0]              hart_i,
    input  logic [csr_pkg::XLEN-1:0]       pc_i,
    input  logic                           ecall_i,
    // response and trap
    output logic                           rsp_valid_o,
    output logic                           trap_valid_o,
    output logic [HART_W-1:0]              rsp_hart_o,
    output logic [4:0]                     rsp_rd_o,
    output logic [csr_pkg::XLEN-1:0]       rsp_rdata_o,
    output logic [csr_pkg::XLEN-1:0]       trap_pc_o
);
    import csr_pkg::*;

    logic                  cmd_valid;
    logic [N_HARTS-1:0]    cmd_sel;
    logic [OP_NUM-1:0]     cmd_op;
    logic [CSR_ADDR_W-1:0] cmd_addr;
    logic [XLEN-1:0]       cmd_operand;
    logic                  cmd_wen;
    logic                  cmd_ren;
    logic [XLEN-1:0]       cmd_pc;
    logic [4:0]            cmd_rd;
    logic [HART_W-1:0]     cmd_hart;
    logic                  cmd_ecall;

    logic [XLEN-1:0] hart_rdata [N_HARTS];
    logic [XLEN-1:0] hart_mtvec [N_HARTS];

    csr_cmd_decoder #(
        .N_HARTS (N_HARTS),
        .HART_W  (HART_W)
    ) u_decoder (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .req_i         (req_i),
        .funct3_i      (funct3_i),
        .csr_addr_i    (csr_addr_i),
        .rs1_i         (rs1_i),
        .rs1_data_i    (rs1_data_i),
        .rd_i          (rd_i),
        .hart_i        (hart_i),
        .pc_i          (pc_i),
        .ecall_i       (ecall_i),
        .cmd_valid_o   (cmd_valid),
        .cmd_sel_o     (cmd_sel),
        .cmd_op_o      (cmd_op),
        .cmd_addr_o    (cmd_addr),
        .cmd_operand_o (cmd_operand),
        .cmd_wen_o     (cmd_wen),
        .cmd_ren_o     (cmd_ren),
        .cmd_pc_o      (cmd_pc),
        .cmd_rd_o      (cmd_rd),
        .cmd_hart_o    (cmd_hart),
        .cmd_ecall_o   (cmd_ecall)
    );

    // one csr file per hart, command broadcast
    for (genvar i = 0; i < N_HARTS; i++) begin : g_hart
        csr_file #(
            .HART_ID (i)
        ) u_csr_file (
            .clk       (clk),
            .arst_n_i  (arst_n_i),
            .sel_i     (cmd_sel[i]),
            .op_i      (cmd_op),
            .addr_i    (cmd_addr),
            .operand_i (cmd_operand),
            .wen_i     (cmd_wen),
            .ren_i     (cmd_ren),
            .pc_i      (cmd_pc),
            .rdata_o   (hart_rdata[i]),
            .mtvec_o   (hart_mtvec[i])
        );
    end

    csr_rsp_collector #(
        .N_HARTS (N_HARTS),
        .HART_W  (HART_W)
    ) u_collector (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .cmd_valid_i  (cmd_valid),
        .cmd_ecall_i  (cmd_ecall),
        .cmd_hart_i   (cmd_hart),
        .cmd_rd_i     (cmd_rd),
        .hart_rdata_i (hart_rdata),
        .hart_mtvec_i (hart_mtvec),
        .rsp_valid_o  (rsp_valid_o),
        .trap_valid_o (trap_valid_o),
        .rsp_hart_o   (rsp_hart_o),
        .rsp_rd_o     (rsp_rd_o),
        .rsp_rdata_o  (rsp_rdata_o),
        .trap_pc_o    (trap_pc_o)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_csr_subsystem

out=$(./obj_dir/Vtb_csr_subsystem)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'NO ERRORS'; then
    exit 0
fi
exit 1

// ==== sim.f ====
hdl/csr_pkg.sv
hdl/csr_cmd_decoder.sv
hdl/csr_file.sv
hdl/csr_rsp_collector.sv
hdl/csr_subsystem.sv
tb/tb_csr_subsystem.sv

// ==== tb/tb_csr_subsystem.sv ====
`timescale 1ns/1ps

module tb_csr_subsystem;
    import csr_pkg::*;

    localparam int N_HARTS       = 4;
    localparam int HART_W        = 2;
    localparam int DRAIN_TIMEOUT = 20;
    localparam logic [CSR_ADDR_W-1:0] CSR_UNIMPL = 12'h7c0;

    typedef struct packed {
        logic [31:0]       due;
        logic              rsp_v;
        logic              trap_v;
        logic [HART_W-1:0] hart;
        logic [4:0]        rd;
        logic [XLEN-1:0]   data;
        logic [XLEN-1:0]   trap_pc;
    } exp_t;

    logic                  clk;
    logic                  arst_n;
    logic                  req;
    logic [2:0]            funct3;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic [4:0]            rs1;
    logic [XLEN-1:0]       rs1_data;
    logic [4:0]            rd;
    logic [HART_W-1:0]     hart;
    logic [XLEN-1:0]       pc;
    logic                  ecall;
    logic                  rsp_valid_o;
    logic                  trap_valid_o;
    logic [HART_W-1:0]     rsp_hart_o;
    logic [4:0]            rsp_rd_o;
    logic [XLEN-1:0]       rsp_rdata_o;
    logic [XLEN-1:0]       trap_pc_o;

    logic [XLEN-1:0] model_csr [N_HARTS][4]; // mstatus, mtvec, mepc, mcause
    exp_t            exp_q[$];
    logic [31:0]     cycle_cnt = '0;
    logic [31:0]     lcg_state = 32'h7121_1b69;
    int              err_cnt;
    int              timeout_cnt;

    csr_subsystem #(
        .N_HARTS (N_HARTS),
        .HART_W  (HART_W)
    ) u_csr_subsystem (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .req_i        (req),
        .funct3_i     (funct3),
        .csr_addr_i   (csr_addr),
        .rs1_i        (rs1),
        .rs1_data_i   (rs1_data),
        .rd_i         (rd),
        .hart_i       (hart),
        .pc_i         (pc),
        .ecall_i      (ecall),
        .rsp_valid_o  (rsp_valid_o),
        .trap_valid_o (trap_valid_o),
        .rsp_hart_o   (rsp_hart_o),
        .rsp_rd_o     (rsp_rd_o),
        .rsp_rdata_o  (rsp_rdata_o),
        .trap_pc_o    (trap_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 32'd1;
    end

    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic csr_slot(input logic [CSR_ADDR_W-1:0] addr, output logic [1:0] slot);
        slot = 2'd0;
        case (addr)
            CSR_MSTATUS: slot = 2'd0;
            CSR_MTVEC:   slot = 2'd1;
            CSR_MEPC:    slot = 2'd2;
            CSR_MCAUSE:  slot = 2'd3;
            default:     return 1'b0;
        endcase
        return 1'b1;
    endfunction

    function automatic logic [XLEN-1:0] model_read(input logic [HART_W-1:0] h,
                                                   input logic [CSR_ADDR_W-1:0] addr);
        logic [1:0]      slot;
        logic [XLEN-1:0] val;
        case (addr)
            CSR_MVENDORID: val = VENDOR_ID;
            CSR_MARCHID:   val = ARCH_ID;
            CSR_MHARTID:   val = XLEN'(h);
            default:       val = '0; // unimplemented
        endcase
        if (csr_slot(addr, slot)) begin
            val = model_csr[h][slot];
        end
        return val;
    endfunction

    // applies one request to the model, returns what the DUT should answer
    function automatic exp_t ref_model(input logic op_ecall, input logic [2:0] op_f3,
                                       input logic [CSR_ADDR_W-1:0] op_addr,
                                       input logic [4:0] op_rs1, input logic [XLEN-1:0] op_data,
                                       input logic [4:0] op_rd, input logic [HART_W-1:0] op_hart,
                                       input logic [XLEN-1:0] op_pc);
        exp_t            e;
        logic [XLEN-1:0] old;
        logic [XLEN-1:0] opnd;
        logic [XLEN-1:0] nv;
        logic            wr;
        logic            rd_en;
        logic [1:0]      slot;
        e      = '0;
        e.hart = op_hart;
        if (op_ecall) begin
            e.trap_v               = 1'b1;
            e.trap_pc              = model_csr[op_hart][1];
            model_csr[op_hart][2] = op_pc;
            model_csr[op_hart][3] = CAUSE_ECALL_M;
            return e;
        end
        old  = model_read(op_hart, op_addr);
        opnd = op_data;
        if (op_f3 == F3_CSRRWI || op_f3 == F3_CSRRSI || op_f3 == F3_CSRRCI) begin
            opnd = {27'd0, op_rs1};
        end
        nv    = opnd;
        wr    = 1'b0;
        rd_en = 1'b0;
        case (op_f3)
            F3_CSRRW, F3_CSRRWI: begin
                wr    = 1'b1;
                rd_en = (op_rd != 5'd0);
            end
            F3_CSRRS, F3_CSRRSI: begin
                nv    = old | opnd;
                wr    = (op_rs1 != 5'd0);
                rd_en = 1'b1;
            end
            F3_CSRRC, F3_CSRRCI: begin
                nv    = old & ~opnd;
                wr    = (op_rs1 != 5'd0);
                rd_en = 1'b1;
            end
            default: ;
        endcase
        e.rsp_v = 1'b1;
        e.rd    = op_rd;
        e.data  = rd_en ? old : '0;
        if (wr && csr_slot(op_addr, slot)) begin
            model_csr[op_hart][slot] = nv;
        end
        return e;
    endfunction

    function automatic logic [CSR_ADDR_W-1:0] pick_addr(input logic [2:0] sel);
        case (sel)
            3'd0:    return CSR_MSTATUS;
            3'd1:    return CSR_MTVEC;
            3'd2:    return CSR_MEPC;
            3'd3:    return CSR_MCAUSE;
            3'd4:    return CSR_MVENDORID;
            3'd5:    return CSR_MHARTID;
            3'd6:    return CSR_UNIMPL;
            default: return CSR_MARCHID;
        endcase
    endfunction

    task automatic issue(input logic op_ecall, input logic [2:0] op_f3,
                         input logic [CSR_ADDR_W-1:0] op_addr, input logic [4:0] op_rs1,
                         input logic [XLEN-1:0] op_data, input logic [4:0] op_rd,
                         input logic [HART_W-1:0] op_hart, input logic [XLEN-1:0] op_pc);
        exp_t e;
        @(negedge clk);
        req      = 1'b1;
        ecall    = op_ecall;
        funct3   = op_f3;
        csr_addr = op_addr;
        rs1      = op_rs1;
        rs1_data = op_data;
        rd       = op_rd;
        hart     = op_hart;
        pc       = op_pc;
        e        = ref_model(op_ecall, op_f3, op_addr, op_rs1, op_data, op_rd, op_hart, op_pc);
        e.due    = cycle_cnt + 32'd2; // fixed two clock latency
        exp_q.push_back(e);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        req   = 1'b0;
        ecall = 1'b0;
    endtask

    task automatic read_csr(input logic [HART_W-1:0] h, input logic [CSR_ADDR_W-1:0] addr);
        issue(1'b0, F3_CSRRS, addr, 5'd0, 32'hffff_ffff, 5'd7, h, '0);
    endtask

    task automatic read_all(input logic [HART_W-1:0] h);
        for (int s = 0; s < 8; s++) begin
            read_csr(h, pick_addr(3'(s)));
        end
    endtask

    task automatic random_req(input logic [HART_W-1:0] h, input logic [CSR_ADDR_W-1:0] addr,
                              input logic allow_ecall);
        logic [31:0] r;
        logic [31:0] data;
        logic [31:0] epc;
        logic [2:0]  f3;
        logic [4:0]  src;
        logic [4:0]  dst;
        r    = rand32();
        data = rand32();
        epc  = rand32() & 32'hffff_fffc;
        case (r[2:0])
            3'd1:       f3 = F3_CSRRS;
            3'd2:       f3 = F3_CSRRC;
            3'd3, 3'd7: f3 = F3_CSRRWI;
            3'd4:       f3 = F3_CSRRSI;
            3'd5:       f3 = F3_CSRRCI;
            default:    f3 = F3_CSRRW;
        endcase
        src = (r[4:3] == 2'd0) ? 5'd0 : r[9:5];
        dst = (r[11:10] == 2'd0) ? 5'd0 : r[16:12];
        issue(allow_ecall && (r[31:28] == 4'd0), f3, addr, src, data, dst, h, epc);
    endtask

    task automatic end_run();
        $display("check errors: %0d, timeouts: %0d", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    // compare process
    always @(negedge clk) begin
        exp_t e;
        if (arst_n) begin
            e = '0;
            if (exp_q.size() > 0 && exp_q[0].due == cycle_cnt) begin
                e = exp_q.pop_front();
            end
            if (rsp_valid_o !== e.rsp_v) begin
                $display("error rsp_valid_o: got %h expected %h", rsp_valid_o, e.rsp_v);
                err_cnt++;
            end
            if (trap_valid_o !== e.trap_v) begin
                $display("error trap_valid_o: got %h expected %h", trap_valid_o, e.trap_v);
                err_cnt++;
            end
            if ((e.rsp_v || e.trap_v) && rsp_hart_o !== e.hart) begin
                $display("error rsp_hart_o: got %h expected %h", rsp_hart_o, e.hart);
                err_cnt++;
            end
            if (e.rsp_v && rsp_rd_o !== e.rd) begin
                $display("error rsp_rd_o: got %h expected %h", rsp_rd_o, e.rd);
                err_cnt++;
            end
            if (e.rsp_v && rsp_rdata_o !== e.data) begin
                $display("error rsp_rdata_o: got %h expected %h", rsp_rdata_o, e.data);
                err_cnt++;
            end
            if (e.trap_v && trap_pc_o !== e.trap_pc) begin
                $display("error trap_pc_o: got %h expected %h", trap_pc_o, e.trap_pc);
                err_cnt++;
            end
        end
    end

    initial begin
        int          wait_cnt;
        logic [31:0] r;
        arst_n      = 1'b0;
        req         = 1'b0;
        funct3      = '0;
        csr_addr    = '0;
        rs1         = '0;
        rs1_data    = '0;
        rd          = '0;
        hart        = '0;
        pc          = '0;
        ecall       = 1'b0;
        err_cnt     = 0;
        timeout_cnt = 0;
        for (int h = 0; h < N_HARTS; h++) begin
            for (int s = 0; s < 4; s++) begin
                model_csr[h][s] = '0;
            end
        end
        repeat (16) @(negedge clk);
        arst_n = 1'b1;

        for (int h = 0; h < N_HARTS; h++) begin
            read_all(HART_W'(h)); // reset values and identity
        end

        // register and immediate forms on hart 1
        issue(1'b0, F3_CSRRW, CSR_MSTATUS, 5'd3, 32'hdead_beef, 5'd4, 2'd1, '0);
        issue(1'b0, F3_CSRRS, CSR_MSTATUS, 5'd3, 32'h0000_f0f0, 5'd4, 2'd1, '0);
        issue(1'b0, F3_CSRRC, CSR_MSTATUS, 5'd3, 32'h0000_00ff, 5'd4, 2'd1, '0);
        issue(1'b0, F3_CSRRS, CSR_MSTATUS, 5'd0, 32'hffff_ffff, 5'd4, 2'd1, '0);
        issue(1'b0, F3_CSRRC, CSR_MSTATUS, 5'd0, 32'hffff_ffff, 5'd4, 2'd1, '0);
        read_csr(2'd1, CSR_MSTATUS);
        issue(1'b0, F3_CSRRWI, CSR_MTVEC, 5'h11, 32'h1234_5678, 5'd9, 2'd1, '0);
        issue(1'b0, F3_CSRRSI, CSR_MTVEC, 5'h0a, 32'h1234_5678, 5'd9, 2'd1, '0);
        issue(1'b0, F3_CSRRCI, CSR_MTVEC, 5'h03, 32'h1234_5678, 5'd9, 2'd1, '0);
        issue(1'b0, F3_CSRRSI, CSR_MTVEC, 5'h00, 32'h1234_5678, 5'd9, 2'd1, '0);
        read_csr(2'd1, CSR_MTVEC);
        issue(1'b0, F3_CSRRW, CSR_MSTATUS, 5'd2, 32'h0000_1000, 5'd0, 2'd1, '0); // rd x0
        read_csr(2'd1, CSR_MSTATUS);
        idle_cycle();

        // ecall after an mtvec write and back-to-back
        issue(1'b0, F3_CSRRW, CSR_MTVEC, 5'd5, 32'h8000_0100, 5'd1, 2'd2, '0);
        idle_cycle();
        issue(1'b1, F3_CSRRW, CSR_MTVEC, 5'd0, '0, 5'd0, 2'd2, 32'h0000_2468);
        read_csr(2'd2, CSR_MEPC);
        read_csr(2'd2, CSR_MCAUSE);
        issue(1'b0, F3_CSRRW, CSR_MTVEC, 5'd5, 32'h8000_0200, 5'd1, 2'd0, '0);
        issue(1'b1, F3_CSRRW, CSR_MTVEC, 5'd0, '0, 5'd0, 2'd0, 32'h0000_0abc);

        repeat (40) random_req(2'd3, CSR_MTVEC, 1'b0);
        repeat (30) random_req(2'd0, CSR_MCAUSE, 1'b1);
        repeat (300) begin
            r = rand32();
            random_req(r[1:0], pick_addr(r[4:2]), 1'b1);
        end
        for (int h = 0; h < N_HARTS; h++) begin
            read_all(HART_W'(h));
        end
        idle_cycle();

        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < DRAIN_TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d responses never arrived", exp_q.size());
            timeout_cnt++;
        end
        end_run();
    end

endmodule
